// File: all.f
+incdir+.
mig_mem_pkg.sv
ddr_refresh_sched.sv
ddr_user_emu.sv
mig_picorv_bridge.sv
mig_mem_top.sv
mig_mem_chk.sv
mig_mem_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := mig_mem_tb
RTL_TOP   := mig_mem_top
FILELIST  := all.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
RUNFLAGS  := +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) $(RUNFLAGS)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// File: mig_mem_tb.sv
`include "mig_mem_cfg.svh"

module mig_mem_tb import mig_mem_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 5;
    localparam int DEPTH         = 2 ** `MEM_AW;
    localparam int N_DIRECTED    = 34;
    localparam int N_REFRESH_RUN = 120;
    localparam int N_RANDOM      = 300;
    localparam int N_TXN         = 2 + DEPTH + N_DIRECTED + N_REFRESH_RUN + N_RANDOM;
    // Refresh ahead of a read burst, doubled for margin
    localparam int TXN_CYCLES    = 2 * (`REFRESH_CYCLES + `ACK_DELAY + `READ_LATENCY + 16);
    localparam int TIMEOUT_NS    =
        (RESET_CYCLES + `INIT_CYCLES + N_TXN * TXN_CYCLES) * CLK_PERIOD;

    logic        clk90;
    logic        sys_rst180;
    mem_req_t    mem_req;
    logic        mem_valid;
    logic        mem_ready;
    mem_data_t   mem_rdata;

    logic [31:0] seed;
    mem_data_t   ref_mem [DEPTH];
    int          refresh_seen = 0;

    mig_mem_top UUT (
        .clk90      (clk90),
        .sys_rst180 (sys_rst180),
        .mem_req    (mem_req),
        .mem_valid  (mem_valid),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata)
    );

    bind mig_mem_top mig_mem_chk u_chk (
        .clk90            (clk90),
        .sys_rst180       (sys_rst180),
        .mem_valid        (mem_valid),
        .mem_ready        (mem_ready),
        .user_cmd         (user_cmd),
        .user_cmd_ack     (user_cmd_ack),
        .auto_refresh_req (auto_refresh_req),
        .init_done        (init_done)
    );

    always #(CLK_PERIOD / 2) clk90 = ~clk90;

    always @(posedge UUT.ar_done) refresh_seen = refresh_seen + 1;

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic mem_data_t fill_word(input mem_addr_t a);
        return 32'h9E37_79B9 ^ ({8'h00, a} * 32'd40503);
    endfunction

    // Strobed bytes replace, the rest keep their old value
    function automatic mem_data_t merge_bytes(input mem_data_t old_word,
                                              input mem_data_t new_word,
                                              input mem_strb_t strb);
        mem_data_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // One native transaction, zero strobe reads and checks
    task automatic mem_access(input string test, input mem_addr_t addr,
                              input mem_data_t wdata, input mem_strb_t strb);
        logic [`MEM_AW-1:0] idx;
        mem_data_t          expected;
        idx      = addr[`MEM_AW:1];
        expected = ref_mem[idx];
        @(negedge clk90);
        mem_req.addr  = addr;
        mem_req.wdata = wdata;
        mem_req.strb  = strb;
        mem_valid     = 1'b1;
        do begin
            @(negedge clk90);
        end while (!mem_ready);
        assert (UUT.init_done)
            else stop_with_failure($sformatf("%s: access completed before init_done", test));
        if (strb != '0) begin
            ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, strb);
        end else begin
            assert (mem_rdata == expected)
                else stop_with_failure($sformatf("ERR %s: addr %06h expected %08h actual %08h",
                                                 test, addr, expected, mem_rdata));
        end
        @(negedge clk90);
        mem_valid = 1'b0;
    endtask

    task automatic random_access(input string test);
        logic [31:0] r;
        mem_addr_t   addr;
        mem_strb_t   strb;
        r    = next_rand();
        // Bits 10:7 sit above the stored index
        addr = {13'd0, r[14:11], r[6:0]};
        strb = r[31] ? 4'h0 : r[19:16];
        mem_access(test, addr, next_rand(), strb);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        mem_addr_t addr;
        int        refresh_start;
        clk90      = 1'b0;
        sys_rst180 = 1'b1;
        mem_valid  = 1'b0;
        mem_req    = '0;
        seed       = 32'h68bd;
        repeat (RESET_CYCLES) @(negedge clk90);
        sys_rst180 = 1'b0;

        // Request raised while init is still running
        mem_access("first_access", 24'h000024, 32'h1234_5678, 4'hF);
        mem_access("first_access", 24'h000024, '0, 4'h0);

        for (int i = 0; i < DEPTH; i++) begin
            addr = mem_addr_t'(i * 2);
            mem_access("fill", addr, fill_word(addr), 4'hF);
        end

        for (int k = 1; k < 15; k++) begin
            addr = mem_addr_t'(8 * k + 1);
            mem_access("byte_strobe", addr, next_rand(), mem_strb_t'(k));
            mem_access("byte_strobe", addr, '0, 4'h0);
        end

        addr = 24'h00002a;
        mem_access("aliasing", addr, 32'hA11A_5ED0, 4'hF);
        mem_access("aliasing", addr ^ 24'h000001, '0, 4'h0);
        mem_access("aliasing", addr | (24'h1 << (`MEM_AW + 1)), '0, 4'h0);
        mem_access("aliasing", addr | 24'h7ff000, '0, 4'h0);
        // Write through a far alias, read back at the base
        mem_access("aliasing", addr | 24'h400081, 32'h0BAD_F00D, 4'h3);
        mem_access("aliasing", addr, '0, 4'h0);

        refresh_start = refresh_seen;
        for (int n = 0; n < N_REFRESH_RUN; n++) begin
            random_access("refresh_run");
        end
        assert (refresh_seen - refresh_start >= 3)
            else stop_with_failure("refresh_run: too few refreshes happened during traffic");

        for (int n = 0; n < N_RANDOM; n++) begin
            random_access("random_mix");
        end

        @(negedge clk90);
        if (UUT.u_chk.violation) begin
            stop_with_failure("protocol assertion fired in mig_mem_chk");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

    always @(negedge clk90) begin
        if (UUT.u_chk.violation) begin
            stop_with_failure("protocol assertion fired in mig_mem_chk");
        end
    end

    initial begin
        #(TIMEOUT_NS);
        stop_with_failure($sformatf("watchdog expired after %0d ns, the memory handshake hung",
                                    TIMEOUT_NS));
    end

endmodule

// File: mig_mem_chk.sv
module mig_mem_chk import mig_mem_pkg::*; (
    input logic      clk90,
    input logic      sys_rst180,
    input logic      mem_valid,
    input logic      mem_ready,
    input user_cmd_t user_cmd,
    input logic      user_cmd_ack,
    input logic      auto_refresh_req,
    input logic      init_done
);

    timeunit 1ns;
    timeprecision 1ps;

    logic violation;
    logic rw_cmd;

    initial violation = 1'b0;

    assign rw_cmd = (user_cmd.cmd == cmd_write) || (user_cmd.cmd == cmd_read);

    //////////////////////////////////////////////////////////////////////
    // User interface protocol
    //////////////////////////////////////////////////////////////////////

    ack_needs_cmd: assert property (@(posedge clk90) disable iff (sys_rst180)
        $rose(user_cmd_ack) |-> user_cmd.cmd != cmd_nop)
        else begin
            violation = 1'b1;
            $error("user_cmd_ack rose while the command was nop");
        end

    // Start decided on the previous edge, when refresh was still low
    no_cmd_in_refresh: assert property (@(posedge clk90) disable iff (sys_rst180)
        rw_cmd && !$past(rw_cmd) |-> !$past(auto_refresh_req))
        else begin
            violation = 1'b1;
            $error("write or read command started while auto_refresh_req was high");
        end

    no_cmd_before_init: assert property (@(posedge clk90) disable iff (sys_rst180)
        rw_cmd |-> init_done)
        else begin
            violation = 1'b1;
            $error("write or read command issued before init_done");
        end

    //////////////////////////////////////////////////////////////////////
    // Native port
    //////////////////////////////////////////////////////////////////////

    // Registered response, so ready trails valid by one cycle
    ready_needs_valid: assert property (@(posedge clk90) disable iff (sys_rst180)
        mem_ready |-> $past(mem_valid))
        else begin
            violation = 1'b1;
            $error("mem_ready high without a request on mem_valid");
        end

endmodule

// File: mig_mem_top.sv
module mig_mem_top import mig_mem_pkg::*; (
    input  logic      clk90,
    input  logic      sys_rst180,
    input  mem_req_t  mem_req,
    input  logic      mem_valid,
    output logic      mem_ready,
    output mem_data_t mem_rdata
);

    // Controller user interface
    user_cmd_t user_cmd;
    user_wr_t  user_wr;
    mem_data_t user_rd_data;
    logic      burst_done;
    logic      user_cmd_ack;
    logic      user_data_valid;
    logic      init_done;

    // Refresh handshake
    logic      auto_refresh_req;
    logic      ar_done;

    mig_picorv_bridge u_bridge (
        .clk90            (clk90),
        .sys_rst180       (sys_rst180),
        .mem_req          (mem_req),
        .mem_valid        (mem_valid),
        .mem_ready        (mem_ready),
        .mem_rdata        (mem_rdata),
        .auto_refresh_req (auto_refresh_req),
        .ar_done          (ar_done),
        .init_done        (init_done),
        .user_cmd_ack     (user_cmd_ack),
        .user_rd_data     (user_rd_data),
        .user_data_valid  (user_data_valid),
        .user_cmd         (user_cmd),
        .user_wr          (user_wr),
        .burst_done       (burst_done)
    );

    ddr_refresh_sched u_refresh_sched (
        .clk90            (clk90),
        .sys_rst180       (sys_rst180),
        .init_done        (init_done),
        .ar_done          (ar_done),
        .auto_refresh_req (auto_refresh_req)
    );

    ddr_user_emu u_user_emu (
        .clk90            (clk90),
        .sys_rst180       (sys_rst180),
        .user_cmd         (user_cmd),
        .user_wr          (user_wr),
        .burst_done       (burst_done),
        .auto_refresh_req (auto_refresh_req),
        .user_cmd_ack     (user_cmd_ack),
        .user_rd_data     (user_rd_data),
        .user_data_valid  (user_data_valid),
        .init_done        (init_done),
        .ar_done          (ar_done)
    );

endmodule

// File: mig_picorv_bridge.sv
module mig_picorv_bridge import mig_mem_pkg::*; (
    input  logic      clk90,
    input  logic      sys_rst180,
    input  mem_req_t  mem_req,
    input  logic      mem_valid,
    output logic      mem_ready,
    output mem_data_t mem_rdata,
    input  logic      auto_refresh_req,
    input  logic      ar_done,
    input  logic      init_done,
    input  logic      user_cmd_ack,
    input  mem_data_t user_rd_data,
    input  logic      user_data_valid,
    output user_cmd_t user_cmd,
    output user_wr_t  user_wr,
    output logic      burst_done
);

    bridge_state_t   state;
    datapath_state_t dp_state;
    logic [1:0]      wait_cnt;
    logic            rd_captured;

    // Read word already taken by the datapath
    assign rd_captured = (dp_state == ds_read) || (dp_state == ds_wait);

    //////////////////////////////////////////////////////////////////////
    // Command FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk90) begin
        if (sys_rst180) begin
            state         <= bs_startup;
            user_cmd.cmd  <= cmd_nop;
            user_cmd.addr <= '0;
            burst_done    <= 1'b0;
            mem_ready     <= 1'b0;
            wait_cnt      <= 2'd0;
        end else begin
            case (state)
                bs_startup: begin
                    mem_ready <= 1'b0;
                    if (!init_done) begin
                        user_cmd.cmd <= cmd_init;
                        state        <= bs_wait_init;
                    end else begin
                        state <= bs_idle;
                    end
                end
                bs_wait_init: begin
                    // Init is a one-cycle command without acknowledge
                    user_cmd.cmd <= cmd_nop;
                    if (init_done) begin
                        state <= bs_idle;
                    end
                end
                bs_idle: begin
                    mem_ready <= 1'b0;
                    if (auto_refresh_req) begin
                        state <= bs_wait_refresh;
                    end else if (mem_valid && !mem_ready && !user_cmd_ack) begin
                        // Skip the cycle right after a ready, master still holds valid
                        user_cmd.addr <= mem_req.addr[23:1];
                        if (mem_req.strb != '0) begin
                            user_cmd.cmd <= cmd_write;
                            state        <= bs_write_cmd;
                        end else begin
                            user_cmd.cmd <= cmd_read;
                            state        <= bs_read_cmd;
                        end
                    end
                end
                bs_wait_refresh: begin
                    if (ar_done) begin
                        state <= bs_idle;
                    end
                end
                bs_write_cmd: begin
                    if (user_cmd_ack) begin
                        wait_cnt <= 2'd3;
                        state    <= bs_write_wait;
                    end
                end
                bs_write_wait: begin
                    if (wait_cnt == 2'd1) begin
                        burst_done <= 1'b1;
                        wait_cnt   <= 2'd2;
                        state      <= bs_write_done;
                    end else begin
                        wait_cnt <= wait_cnt - 2'd1;
                    end
                end
                bs_write_done: begin
                    user_cmd.cmd <= cmd_nop;
                    if (wait_cnt == 2'd1) begin
                        burst_done <= 1'b0;
                        mem_ready  <= 1'b1;
                        state      <= bs_idle;
                    end else begin
                        wait_cnt <= wait_cnt - 2'd1;
                    end
                end
                bs_read_cmd: begin
                    if (user_cmd_ack) begin
                        wait_cnt <= 2'd3;
                        state    <= bs_read_wait;
                    end
                end
                bs_read_wait: begin
                    if (wait_cnt == 2'd1) begin
                        burst_done <= 1'b1;
                        wait_cnt   <= 2'd2;
                        state      <= bs_read_burst;
                    end else begin
                        wait_cnt <= wait_cnt - 2'd1;
                    end
                end
                bs_read_burst: begin
                    user_cmd.cmd <= cmd_nop;
                    if (wait_cnt == 2'd1) begin
                        burst_done <= 1'b0;
                        if (rd_captured) begin
                            state <= bs_read_done;
                        end
                    end else begin
                        wait_cnt <= wait_cnt - 2'd1;
                    end
                end
                bs_read_done: begin
                    // Ready held until the master lets go
                    if (!mem_valid) begin
                        mem_ready <= 1'b0;
                        state     <= bs_idle;
                    end else begin
                        mem_ready <= 1'b1;
                    end
                end
                default: state <= bs_startup;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Datapath FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk90) begin
        if (sys_rst180 || !init_done) begin
            dp_state     <= ds_idle;
            user_wr.mask <= '1;
        end else begin
            case (dp_state)
                ds_idle: begin
                    if (user_cmd_ack) begin
                        if (user_cmd.cmd == cmd_write) begin
                            user_wr.data <= mem_req.wdata;
                            user_wr.mask <= ~mem_req.strb;
                            dp_state     <= ds_write;
                        end else if (user_cmd.cmd == cmd_read) begin
                            dp_state <= ds_read_wait;
                        end
                    end
                end
                ds_write: begin
                    // Second burst word is fully masked
                    user_wr.mask <= '1;
                    dp_state     <= ds_wait;
                end
                ds_read_wait: begin
                    if (user_data_valid) begin
                        mem_rdata <= user_rd_data;
                        dp_state  <= ds_read;
                    end
                end
                ds_read: dp_state <= ds_wait;
                ds_wait: begin
                    if (!user_cmd_ack) begin
                        dp_state <= ds_idle;
                    end
                end
                default: dp_state <= ds_idle;
            endcase
        end
    end

endmodule

// File: ddr_user_emu.sv
`include "mig_mem_cfg.svh"

module ddr_user_emu import mig_mem_pkg::*; (
    input  logic      clk90,
    input  logic      sys_rst180,
    input  user_cmd_t user_cmd,
    input  user_wr_t  user_wr,
    input  logic      burst_done,
    input  logic      auto_refresh_req,
    output logic      user_cmd_ack,
    output mem_data_t user_rd_data,
    output logic      user_data_valid,
    output logic      init_done,
    output logic      ar_done
);

    localparam int CW     = `EMU_CNT_W;
    localparam int DEPTH  = 2 ** `MEM_AW;
    localparam int NBYTES = $bits(mem_strb_t);

    emu_state_t         state;
    logic [CW-1:0]      cnt;
    logic [`MEM_AW-1:0] idx;
    logic               is_read;
    logic               bd_q;
    logic               burst_end;
    mem_data_t          store [DEPTH];

    // Bridge has closed its burst_done window
    assign burst_end = bd_q && !burst_done;

    //////////////////////////////////////////////////////////////////////
    // Burst store, word 0 only
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk90) begin
        if (state == es_write && cnt == '0) begin
            for (int b = 0; b < NBYTES; b++) begin
                if (!user_wr.mask[b]) begin
                    store[idx][8*b +: 8] <= user_wr.data[8*b +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Controller FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk90) begin
        if (sys_rst180) begin
            state           <= es_idle;
            cnt             <= '0;
            user_cmd_ack    <= 1'b0;
            user_data_valid <= 1'b0;
            init_done       <= 1'b0;
            ar_done         <= 1'b0;
            bd_q            <= 1'b0;
        end else begin
            ar_done <= 1'b0;
            bd_q    <= burst_done;
            case (state)
                es_idle: begin
                    // ar_done still high means the request is about to clear
                    if (auto_refresh_req && !ar_done && user_cmd.cmd == cmd_nop) begin
                        cnt   <= CW'(`REFRESH_CYCLES - 1);
                        state <= es_refresh;
                    end else if (user_cmd.cmd == cmd_init) begin
                        cnt   <= CW'(`INIT_CYCLES - 1);
                        state <= es_init;
                    end else if (user_cmd.cmd == cmd_write || user_cmd.cmd == cmd_read) begin
                        is_read <= (user_cmd.cmd == cmd_read);
                        idx     <= user_cmd.addr[`MEM_AW-1:0];
                        cnt     <= CW'(`ACK_DELAY - 1);
                        state   <= es_ack;
                    end
                end
                es_init: begin
                    if (cnt == '0) begin
                        init_done <= 1'b1;
                        state     <= es_idle;
                    end else begin
                        cnt <= cnt - CW'(1);
                    end
                end
                es_refresh: begin
                    if (cnt == '0) begin
                        ar_done <= 1'b1;
                        state   <= es_idle;
                    end else begin
                        cnt <= cnt - CW'(1);
                    end
                end
                es_ack: begin
                    if (cnt == '0) begin
                        user_cmd_ack <= 1'b1;
                        if (is_read) begin
                            cnt   <= CW'(`READ_LATENCY - 1);
                            state <= es_read_wait;
                        end else begin
                            // Word 0 shows up the cycle after the acknowledge
                            cnt   <= CW'(1);
                            state <= es_write;
                        end
                    end else begin
                        cnt <= cnt - CW'(1);
                    end
                end
                es_write: begin
                    if (cnt == '0) begin
                        state <= es_burst;
                    end else begin
                        cnt <= cnt - CW'(1);
                    end
                end
                es_read_wait: begin
                    if (cnt == '0) begin
                        user_data_valid <= 1'b1;
                        user_rd_data    <= store[idx];
                        state           <= es_read_word0;
                    end else begin
                        cnt <= cnt - CW'(1);
                    end
                end
                es_read_word0: begin
                    // Second word has no backing storage
                    user_rd_data <= '0;
                    state        <= es_read_word1;
                end
                es_read_word1: begin
                    user_data_valid <= 1'b0;
                    state           <= es_burst;
                end
                es_burst: begin
                    if (burst_end) begin
                        user_cmd_ack <= 1'b0;
                        state        <= es_idle;
                    end
                end
                default: state <= es_idle;
            endcase
        end
    end

endmodule

// File: ddr_refresh_sched.sv
`include "mig_mem_cfg.svh"

module ddr_refresh_sched (
    input  logic clk90,
    input  logic sys_rst180,
    input  logic init_done,
    input  logic ar_done,
    output logic auto_refresh_req
);

    localparam int CNT_W = $clog2(`REFRESH_INTERVAL);

    logic [CNT_W-1:0] interval_cnt;

    //////////////////////////////////////////////////////////////////////
    // Interval count, paused while a request is open
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk90) begin
        if (sys_rst180) begin
            interval_cnt     <= '0;
            auto_refresh_req <= 1'b0;
        end else if (!init_done) begin
            interval_cnt <= '0;
        end else if (auto_refresh_req) begin
            // Held until the controller finishes
            if (ar_done) begin
                auto_refresh_req <= 1'b0;
                interval_cnt     <= '0;
            end
        end else if (interval_cnt == CNT_W'(`REFRESH_INTERVAL - 1)) begin
            auto_refresh_req <= 1'b1;
        end else begin
            interval_cnt <= interval_cnt + CNT_W'(1);
        end
    end

endmodule

// File: mig_mem_pkg.sv
package mig_mem_pkg;

    // Native memory port
    typedef logic [23:0] mem_addr_t;
    typedef logic [31:0] mem_data_t;
    typedef logic [3:0]  mem_strb_t;

    // Burst address, native word address without bit 0
    typedef logic [22:0] user_addr_t;

    typedef enum logic [2:0] {
        cmd_nop   = 3'b000,
        cmd_init  = 3'b010,
        cmd_write = 3'b100,
        cmd_read  = 3'b110
    } ddr_cmd_t;

    typedef struct packed {
        mem_addr_t addr;
        mem_data_t wdata;
        mem_strb_t strb;
    } mem_req_t;

    typedef struct packed {
        ddr_cmd_t   cmd;
        user_addr_t addr;
    } user_cmd_t;

    // Mask bit set means the byte is left alone
    typedef struct packed {
        mem_data_t data;
        mem_strb_t mask;
    } user_wr_t;

    typedef enum logic [3:0] {
        bs_startup,
        bs_wait_init,
        bs_idle,
        bs_wait_refresh,
        bs_write_cmd,
        bs_write_wait,
        bs_write_done,
        bs_read_cmd,
        bs_read_wait,
        bs_read_burst,
        bs_read_done
    } bridge_state_t;

    typedef enum logic [2:0] {
        ds_idle,
        ds_write,
        ds_read_wait,
        ds_read,
        ds_wait
    } datapath_state_t;

    typedef enum logic [3:0] {
        es_idle,
        es_init,
        es_refresh,
        es_ack,
        es_write,
        es_read_wait,
        es_read_word0,
        es_read_word1,
        es_burst
    } emu_state_t;

endpackage

// File: mig_mem_cfg.svh
`ifndef MIG_MEM_CFG_SVH
`define MIG_MEM_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Emulated burst store
//////////////////////////////////////////////////////////////////////

// 2**MEM_AW burst entries, higher user address bits alias
`define MEM_AW 6

//////////////////////////////////////////////////////////////////////
// Refresh
//////////////////////////////////////////////////////////////////////

`define REFRESH_INTERVAL 200
`define REFRESH_CYCLES 12

//////////////////////////////////////////////////////////////////////
// Controller latencies, clk90 cycles
//////////////////////////////////////////////////////////////////////

`define INIT_CYCLES 20
`define ACK_DELAY 2
`define READ_LATENCY 4

// Emulator delay counter, must hold the largest latency above
`define EMU_CNT_W 5

`endif
